//--- verilog/int_cpu_defs.svh
`ifndef INT_CPU_DEFS_SVH
`define INT_CPU_DEFS_SVH

// --------------------
// datapath sizes
// --------------------
`define INT_CPU_XLEN         32  // data word and instruction width
`define INT_CPU_REG_COUNT    16  // x0..x15
`define INT_CPU_REG_IDX_W    4   // register index width
`define INT_CPU_IMM_W        12  // raw immediate width, sign extended in decode

`define INT_CPU_IMEM_DEPTH   64  // instruction words
`define INT_CPU_IMEM_ADDR_W  6   // pc width, log2 of depth

// --------------------
// instruction fields
// --------------------
// imm[31:20] rs2[19:16] rs1[15:12] rd[11:8] opt[7:4] opcode[3:0]
`define INT_CPU_OPC_LSB      0
`define INT_CPU_OPT_LSB      4
`define INT_CPU_RD_LSB       8
`define INT_CPU_RS1_LSB      12
`define INT_CPU_RS2_LSB      16
`define INT_CPU_IMM_LSB      20

`endif

//--- verilog/int_cpu_pkg.sv
`include "int_cpu_defs.svh"

package int_cpu_pkg;

    // --------------------
    // basic types
    // --------------------
    typedef logic [`INT_CPU_XLEN-1:0]        word_t;       // data word or instruction
    typedef logic [`INT_CPU_REG_IDX_W-1:0]   reg_idx_t;    // register number
    typedef logic [`INT_CPU_IMEM_ADDR_W-1:0] imem_addr_t;  // instruction address

    // --------------------
    // encodings
    // --------------------
    typedef enum logic [3:0] {
        OPC_CALC_I = 4'h0,  // rd = rs1 op sext(imm)
        OPC_CALC_R = 4'h1,  // rd = rs1 op rs2
        OPC_HALT   = 4'hA   // end of program
    } opcode_e;

    // values match the opt field directly
    typedef enum logic [3:0] {
        ALU_ADD = 4'h0,
        ALU_SUB = 4'h1,
        ALU_SLL = 4'h2,
        ALU_SRL = 4'h3,
        ALU_SRA = 4'h4,
        ALU_AND = 4'h5,
        ALU_OR  = 4'h6,
        ALU_XOR = 4'h7
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,  // waiting for run_req
        ST_RUN  = 2'd1,  // one instruction per cycle
        ST_DONE = 2'd2   // halted, run_ack high
    } seq_state_e;

endpackage

//--- verilog/instr_mem.sv
`include "int_cpu_defs.svh"

module instr_mem (
    input  logic                    clk,
    input  logic                    imem_we,     // load strobe from outside
    input  int_cpu_pkg::imem_addr_t imem_addr,   // load address
    input  int_cpu_pkg::word_t      imem_wdata,  // load data
    input  int_cpu_pkg::imem_addr_t pc,          // fetch address
    output int_cpu_pkg::word_t      instr        // fetched instruction
);

    int_cpu_pkg::word_t mem [`INT_CPU_IMEM_DEPTH];  // program store, no reset

    // --------------------
    // load port
    // --------------------
    always_ff @(posedge clk) begin
        if (imem_we) begin
            mem[imem_addr] <= imem_wdata;  // only written while idle
        end
    end

    // --------------------
    // fetch
    // --------------------
    // async read so the instruction is ready in the same cycle as pc
    assign instr = mem[pc];

endmodule

//--- verilog/instr_decoder.sv
`include "int_cpu_defs.svh"

module instr_decoder (
    input  int_cpu_pkg::word_t    instr,    // from instr_mem
    input  logic                  exec_en,  // high while running
    output int_cpu_pkg::reg_idx_t rs1,
    output int_cpu_pkg::reg_idx_t rs2,
    output int_cpu_pkg::reg_idx_t rd,
    output int_cpu_pkg::word_t    imm,      // sign extended immediate
    output logic                  use_imm,  // second operand is imm
    output int_cpu_pkg::alu_op_e  alu_op,
    output logic                  reg_we,   // commit result to rd
    output logic                  is_halt   // stop the run
);

    int_cpu_pkg::opcode_e             opcode;    // decoded opcode
    logic [`INT_CPU_IMM_W-1:0]        imm_raw;   // immediate before extension
    logic [$bits(int_cpu_pkg::alu_op_e)-1:0] opt_raw;  // opt field as is
    logic                             is_calc;   // calc_i or calc_r
    logic                             opt_ok;    // opt 0..7

    // --------------------
    // field split
    // --------------------
    assign opcode  = int_cpu_pkg::opcode_e'(
                         instr[`INT_CPU_OPC_LSB +: $bits(int_cpu_pkg::opcode_e)]);
    assign opt_raw = instr[`INT_CPU_OPT_LSB +: $bits(int_cpu_pkg::alu_op_e)];
    assign rd      = instr[`INT_CPU_RD_LSB  +: `INT_CPU_REG_IDX_W];
    assign rs1     = instr[`INT_CPU_RS1_LSB +: `INT_CPU_REG_IDX_W];
    assign rs2     = instr[`INT_CPU_RS2_LSB +: `INT_CPU_REG_IDX_W];
    assign imm_raw = instr[`INT_CPU_IMM_LSB +: `INT_CPU_IMM_W];

    // replicate bit 11 into the upper 20 bits
    assign imm = {{(`INT_CPU_XLEN-`INT_CPU_IMM_W){imm_raw[`INT_CPU_IMM_W-1]}}, imm_raw};

    assign alu_op  = int_cpu_pkg::alu_op_e'(opt_raw);  // opt 8..15 fall to alu default
    assign use_imm = (opcode == int_cpu_pkg::OPC_CALC_I);

    // --------------------
    // control
    // --------------------
    assign is_calc = (opcode == int_cpu_pkg::OPC_CALC_I) ||
                     (opcode == int_cpu_pkg::OPC_CALC_R);
    assign opt_ok  = ~opt_raw[$bits(opt_raw)-1];  // top bit clear means 0..7

    // unknown opcodes and opt 8..15 are no-ops
    assign reg_we  = exec_en && is_calc && opt_ok;
    assign is_halt = exec_en && (opcode == int_cpu_pkg::OPC_HALT);

endmodule

//--- verilog/alu.sv
`include "int_cpu_defs.svh"

module alu (
    input  int_cpu_pkg::word_t   rs1_data,  // first operand
    input  int_cpu_pkg::word_t   rs2_data,  // register second operand
    input  int_cpu_pkg::word_t   imm,       // immediate second operand
    input  logic                 use_imm,
    input  int_cpu_pkg::alu_op_e alu_op,
    output int_cpu_pkg::word_t   result
);

    localparam int SHAMT_W = $clog2(`INT_CPU_XLEN);  // in-range shift bits

    int_cpu_pkg::word_t op_b;       // selected second operand
    logic [SHAMT_W-1:0] shamt;      // low bits of op_b
    logic               shamt_big;  // op_b >= 32, whole word read unsigned

    assign op_b      = use_imm ? imm : rs2_data;
    assign shamt     = op_b[SHAMT_W-1:0];
    assign shamt_big = |op_b[`INT_CPU_XLEN-1:SHAMT_W];

    // --------------------
    // operation select
    // --------------------
    always_comb begin
        case (alu_op)
            int_cpu_pkg::ALU_ADD: result = rs1_data + op_b;
            int_cpu_pkg::ALU_SUB: result = rs1_data - op_b;
            int_cpu_pkg::ALU_SLL: result = shamt_big ? '0 : (rs1_data << shamt);
            int_cpu_pkg::ALU_SRL: result = shamt_big ? '0 : (rs1_data >> shamt);
            int_cpu_pkg::ALU_SRA: begin
                if (shamt_big) begin
                    result = {`INT_CPU_XLEN{rs1_data[`INT_CPU_XLEN-1]}};  // all sign bits
                end else begin
                    result = $signed(rs1_data) >>> shamt;
                end
            end
            int_cpu_pkg::ALU_AND: result = rs1_data & op_b;
            int_cpu_pkg::ALU_OR:  result = rs1_data | op_b;
            int_cpu_pkg::ALU_XOR: result = rs1_data ^ op_b;
            default:              result = '0;  // not written back anyway
        endcase
    end

endmodule

//--- verilog/reg_file.sv
`include "int_cpu_defs.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  int_cpu_pkg::reg_idx_t rs1,
    input  int_cpu_pkg::reg_idx_t rs2,
    output int_cpu_pkg::word_t    rs1_data,
    output int_cpu_pkg::word_t    rs2_data,
    input  int_cpu_pkg::reg_idx_t rd,
    input  logic                  reg_we,
    input  int_cpu_pkg::word_t    wdata,     // alu result
    input  int_cpu_pkg::reg_idx_t dbg_sel,   // debug read index
    output int_cpu_pkg::word_t    dbg_data
);

    int_cpu_pkg::word_t regs [`INT_CPU_REG_COUNT];  // x0 entry stays zero

    // x0 reads as zero on every port
    function automatic int_cpu_pkg::word_t read_reg(input int_cpu_pkg::reg_idx_t idx);
        return (idx == '0) ? '0 : regs[idx];
    endfunction

    // --------------------
    // write port
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `INT_CPU_REG_COUNT; i++) begin
                regs[i] <= '0;  // all registers start at zero
            end
        end else if (reg_we && (rd != '0)) begin
            regs[rd] <= wdata;  // visible to the next instruction
        end
    end

    // --------------------
    // read ports
    // --------------------
    assign rs1_data = read_reg(rs1);
    assign rs2_data = read_reg(rs2);
    assign dbg_data = read_reg(dbg_sel);  // testbench peek

endmodule

//--- verilog/seq_ctrl.sv
module seq_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    run_req,  // four-phase request
    input  logic                    is_halt,  // from decoder, only in ST_RUN
    output int_cpu_pkg::imem_addr_t pc,
    output logic                    exec_en,  // execute the instruction at pc
    output logic                    run_ack   // run finished
);

    int_cpu_pkg::seq_state_e state;       // current state
    int_cpu_pkg::seq_state_e next_state;  // state after this edge

    // --------------------
    // next state
    // --------------------
    always_comb begin
        next_state = state;
        case (state)
            int_cpu_pkg::ST_IDLE: begin
                if (run_req) begin
                    next_state = int_cpu_pkg::ST_RUN;  // start at address 0
                end
            end
            int_cpu_pkg::ST_RUN: begin
                if (is_halt) begin
                    next_state = int_cpu_pkg::ST_DONE;  // halt writes nothing
                end
            end
            int_cpu_pkg::ST_DONE: begin
                if (!run_req) begin
                    next_state = int_cpu_pkg::ST_IDLE;  // ack drops with this edge
                end
            end
            default: next_state = int_cpu_pkg::ST_IDLE;
        endcase
    end

    // --------------------
    // state and pc
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= int_cpu_pkg::ST_IDLE;
            pc    <= '0;
        end else begin
            state <= next_state;
            if ((state == int_cpu_pkg::ST_IDLE) && run_req) begin
                pc <= '0;  // every run starts from the top
            end else if ((state == int_cpu_pkg::ST_RUN) && !is_halt) begin
                pc <= pc + 1'b1;  // one instruction per cycle
            end
        end
    end

    assign exec_en = (state == int_cpu_pkg::ST_RUN);
    assign run_ack = (state == int_cpu_pkg::ST_DONE);  // held while run_req stays high

endmodule

//--- verilog/int_cpu.sv
module int_cpu (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    imem_we,     // program load
    input  int_cpu_pkg::imem_addr_t imem_addr,
    input  int_cpu_pkg::word_t      imem_wdata,
    input  logic                    run_req,     // run handshake
    output logic                    run_ack,
    input  int_cpu_pkg::reg_idx_t   dbg_sel,     // debug register read
    output int_cpu_pkg::word_t      dbg_data
);

    // --------------------
    // datapath wires
    // --------------------
    int_cpu_pkg::imem_addr_t pc;
    logic                    exec_en;
    int_cpu_pkg::word_t      instr;
    int_cpu_pkg::reg_idx_t   rs1, rs2, rd;
    int_cpu_pkg::word_t      imm;
    logic                    use_imm;
    int_cpu_pkg::alu_op_e    alu_op;
    logic                    reg_we;
    logic                    is_halt;
    int_cpu_pkg::word_t      rs1_data, rs2_data;
    int_cpu_pkg::word_t      result;      // write back value

    seq_ctrl seq0 (
        .clk(clk), .rst_n(rst_n),
        .run_req(run_req), .is_halt(is_halt),
        .pc(pc), .exec_en(exec_en), .run_ack(run_ack)
    );

    instr_mem imem0 (
        .clk(clk),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .pc(pc), .instr(instr)
    );

    instr_decoder dec0 (
        .instr(instr), .exec_en(exec_en),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .imm(imm), .use_imm(use_imm), .alu_op(alu_op),
        .reg_we(reg_we), .is_halt(is_halt)
    );

    reg_file rf0 (
        .clk(clk), .rst_n(rst_n),
        .rs1(rs1), .rs2(rs2),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rd(rd), .reg_we(reg_we), .wdata(result),
        .dbg_sel(dbg_sel), .dbg_data(dbg_data)
    );

    alu alu0 (
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .imm(imm), .use_imm(use_imm), .alu_op(alu_op),
        .result(result)
    );

endmodule

//--- bench/tb_int_cpu.sv
module tb_int_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 4;   // ns
    localparam int RESET_CYCLES = 4;
    localparam int NUM_RAND = 16;    // random entries, half calc_i half calc_r

    logic                    clk;
    logic                    rst_n;
    logic                    imem_we;
    int_cpu_pkg::imem_addr_t imem_addr;
    int_cpu_pkg::word_t      imem_wdata;
    logic                    run_req;
    logic                    run_ack;
    int_cpu_pkg::reg_idx_t   dbg_sel;
    int_cpu_pkg::word_t      dbg_data;

    // stimulus table, one row per test, programs packed into prog_q
    string                 t_name [$];
    int                    t_first [$];   // index of first instruction in prog_q
    int                    t_len [$];     // instructions before the halt
    int_cpu_pkg::reg_idx_t t_reg [$];     // register read back
    int_cpu_pkg::word_t    t_exp [$];
    int_cpu_pkg::word_t    prog_q [$];

    int err_count  = 0;
    int pass_count = 0;
    int fail_count = 0;

    int_cpu dut0 (
        .clk(clk), .rst_n(rst_n),
        .imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
        .run_req(run_req), .run_ack(run_ack),
        .dbg_sel(dbg_sel), .dbg_data(dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------
    // instruction builders
    // --------------------
    function automatic int_cpu_pkg::word_t enc(input logic [3:0] opc, input logic [3:0] opt,
                                               input logic [3:0] rd, input logic [3:0] rs1,
                                               input logic [3:0] rs2, input logic [11:0] imm);
        return {imm, rs2, rs1, rd, opt, opc};  // imm rs2 rs1 rd opt opcode
    endfunction

    function automatic int_cpu_pkg::word_t i_op(input logic [3:0] opt, input logic [3:0] rd,
                                                input logic [3:0] rs1, input logic [11:0] imm);
        return enc(4'h0, opt, rd, rs1, 4'h0, imm);
    endfunction

    function automatic int_cpu_pkg::word_t r_op(input logic [3:0] opt, input logic [3:0] rd,
                                                input logic [3:0] rs1, input logic [3:0] rs2);
        return enc(4'h1, opt, rd, rs1, rs2, 12'h000);
    endfunction

    function automatic int_cpu_pkg::word_t sext(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // reference model of one operation, shift amount is the whole operand
    function automatic int_cpu_pkg::word_t ref_calc(input logic [3:0] opt,
                                                    input int_cpu_pkg::word_t a,
                                                    input int_cpu_pkg::word_t b);
        int_cpu_pkg::word_t r;
        case (opt)
            4'd0: r = a + b;
            4'd1: r = a - b;
            4'd2: r = (b > 31) ? 32'h0 : a << b[4:0];
            4'd3: r = (b > 31) ? 32'h0 : a >> b[4:0];
            4'd4: r = (b > 31) ? {32{a[31]}} : int_cpu_pkg::word_t'($signed(a) >>> b[4:0]);
            4'd5: r = a & b;
            4'd6: r = a | b;
            4'd7: r = a ^ b;
            default: r = 32'h0;  // no write expected
        endcase
        return r;
    endfunction

    task automatic add_test(input string name, input int n, input int_cpu_pkg::word_t i0,
                            input int_cpu_pkg::word_t i1, input int_cpu_pkg::word_t i2,
                            input int_cpu_pkg::word_t i3, input int_cpu_pkg::reg_idx_t r,
                            input int_cpu_pkg::word_t exp);
        int_cpu_pkg::word_t ins [4];
        ins = '{i0, i1, i2, i3};
        t_name.push_back(name);
        t_first.push_back(prog_q.size());
        t_len.push_back(n);
        t_reg.push_back(r);
        t_exp.push_back(exp);
        for (int i = 0; i < n; i++) prog_q.push_back(ins[i]);
    endtask

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_word(input string name, input int_cpu_pkg::word_t got,
                              input int_cpu_pkg::word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_ack(input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED run_ack got %h expected %h", got, exp);
            err_count++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;  // drive and sample away from the edge
    endtask

    // load, run, read back, hold the ack, release
    task automatic run_test(input int idx);
        int  errs0;
        bit  seen;
        errs0 = err_count;
        for (int i = 0; i < t_len[idx]; i++) begin
            imem_we    = 1'b1;
            imem_addr  = int_cpu_pkg::imem_addr_t'(i);
            imem_wdata = prog_q[t_first[idx] + i];
            next_cycle();
        end
        imem_addr  = int_cpu_pkg::imem_addr_t'(t_len[idx]);
        imem_wdata = enc(4'hA, 4'h0, 4'h0, 4'h0, 4'h0, 12'h000);  // halt
        next_cycle();
        imem_we = 1'b0;
        dbg_sel = t_reg[idx];
        run_req = 1'b1;
        seen = 1'b0;
        for (int c = 0; c < t_len[idx] + 8 && !seen; c++) begin
            next_cycle();
            seen = run_ack;
        end
        if (!seen) begin
            $display("run_ack never rose for test %0d, the CPU did not halt", idx);
            err_count++;
        end else begin
            check_word("dbg_data", dbg_data, t_exp[idx]);
            repeat (10) begin
                next_cycle();
                check_ack(run_ack, 1'b1);  // held while run_req stays high
            end
        end
        run_req = 1'b0;
        for (int c = 0; c < 2 && run_ack; c++) next_cycle();
        check_ack(run_ack, 1'b0);
        if (err_count == errs0) pass_count++;
        else fail_count++;
        $display("test %0d %s %s", idx, t_name[idx], (err_count == errs0) ? "ok" : "failed");
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        logic [11:0]        pa [5];
        logic [11:0]        pb [5];
        int_cpu_pkg::word_t exp_imm [40];
        int_cpu_pkg::word_t exp_rr [8];
        int_cpu_pkg::word_t exp_neg [8];
        int_cpu_pkg::word_t nop;
        logic [3:0]         opt;
        logic [11:0]        ia;
        logic [11:0]        ib;
        int                 limit;

        rst_n      = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        run_req    = 1'b0;
        dbg_sel    = '0;
        void'($urandom(15316));

        pa      = '{12'd3, 12'd5, 12'd2, 12'd1, 12'd0};
        pb      = '{12'd1, 12'd6, 12'hFFF, 12'd0, 12'd0};  // 2 with -1 shifts to zero
        // one row of eight ops per rs1/imm pair
        exp_imm = '{32'h4, 32'h2, 32'h6, 32'h1, 32'h1, 32'h1, 32'h3, 32'h2,
                    32'hB, 32'hFFFFFFFF, 32'h140, 32'h0, 32'h0, 32'h4, 32'h7, 32'h3,
                    32'h1, 32'h3, 32'h0, 32'h0, 32'h0, 32'h2, 32'hFFFFFFFF, 32'hFFFFFFFD,
                    32'h1, 32'h1, 32'h1, 32'h1, 32'h1, 32'h0, 32'h1, 32'h1,
                    32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0};
        exp_rr  = '{32'h7, 32'h1, 32'h20, 32'h0, 32'h0, 32'h0, 32'h7, 32'h7};  // 4 op 3
        exp_neg = '{32'hFFFFFFFB, 32'hFFFFFFF9, 32'hFFFFFFF4, 32'h7FFFFFFD,
                    32'hFFFFFFFD, 32'h0, 32'hFFFFFFFB, 32'hFFFFFFFB};  // -6 op 1
        nop     = 32'h0;

        for (int p = 0; p < 5; p++) begin
            for (int k = 0; k < 8; k++) begin
                add_test("calc_i", 2, i_op(4'd0, 4'd1, 4'd0, pa[p]),
                         i_op(4'(k), 4'd2, 4'd1, pb[p]), nop, nop, 4'd2,
                         exp_imm[p * 8 + k]);
            end
        end
        for (int k = 0; k < 8; k++) begin
            add_test("calc_r", 3, i_op(4'd0, 4'd3, 4'd0, 12'd4), i_op(4'd0, 4'd2, 4'd0, 12'd3),
                     r_op(4'(k), 4'd4, 4'd3, 4'd2), nop, 4'd4, exp_rr[k]);
        end
        for (int k = 0; k < 8; k++) begin
            add_test("negative src", 3, i_op(4'd0, 4'd2, 4'd0, 12'd6),
                     r_op(4'd1, 4'd1, 4'd0, 4'd2), i_op(4'(k), 4'd3, 4'd1, 12'd1), nop,
                     4'd3, exp_neg[k]);
        end
        add_test("x0 write", 1, i_op(4'd0, 4'd0, 4'd0, 12'd5), nop, nop, nop, 4'd0, 32'h0);
        add_test("opt 8 no-op", 2, i_op(4'd0, 4'd6, 4'd0, 12'd9),
                 enc(4'h0, 4'h8, 4'd6, 4'd0, 4'd0, 12'd1), nop, nop, 4'd6, 32'h9);
        add_test("opcode 3 no-op", 2, i_op(4'd0, 4'd6, 4'd0, 12'd9),
                 enc(4'h3, 4'h0, 4'd6, 4'd0, 4'd0, 12'd1), nop, nop, 4'd6, 32'h9);
        add_test("x5 set", 1, i_op(4'd0, 4'd5, 4'd0, 12'h055), nop, nop, nop, 4'd5, 32'h55);
        add_test("x5 kept", 1, i_op(4'd0, 4'd7, 4'd0, 12'd1), nop, nop, nop, 4'd5, 32'h55);

        for (int k = 0; k < NUM_RAND; k++) begin
            opt = 4'($urandom_range(0, 7));
            ia  = 12'($urandom);
            ib  = 12'($urandom);
            if (opt >= 4'd2 && opt <= 4'd4 && $urandom_range(0, 1) == 1) begin
                ib = 12'($urandom_range(0, 40));  // keep some shifts in range
            end
            if (k % 2 == 0) begin
                add_test("rand calc_i", 2, i_op(4'd0, 4'd1, 4'd0, ia),
                         i_op(opt, 4'd3, 4'd1, ib), nop, nop, 4'd3,
                         ref_calc(opt, sext(ia), sext(ib)));
            end else begin
                add_test("rand calc_r", 3, i_op(4'd0, 4'd1, 4'd0, ia),
                         i_op(4'd0, 4'd2, 4'd0, ib), r_op(opt, 4'd3, 4'd1, 4'd2), nop,
                         4'd3, ref_calc(opt, sext(ia), sext(ib)));
            end
        end

        // load cycles + program length + margin per entry
        limit = RESET_CYCLES + 4;
        foreach (t_len[i]) limit += (t_len[i] + 1) * 2 + 20;
        fork
            begin
                #(limit * CLK_PERIOD);
                $display("watchdog expired after %0d ns, the run did not finish",
                         limit * CLK_PERIOD);
                $display("TEST RESULT: FAIL");
                $finish;
            end
        join_none

        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        next_cycle();
        check_ack(run_ack, 1'b0);  // idle after reset
        $display("reset check %s", (err_count == 0) ? "ok" : "failed");

        foreach (t_name[i]) run_test(i);

        $display("%0d tests passed, %0d tests failed, %0d check errors",
                 pass_count, fail_count, err_count);
        if (err_count == 0 && fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- int_cpu.f
+incdir+verilog
verilog/int_cpu_pkg.sv
verilog/instr_mem.sv
verilog/instr_decoder.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/seq_ctrl.sv
verilog/int_cpu.sv
bench/tb_int_cpu.sv
